// File: hdl/ppu_defines.svh
// Widths and thresholds of the N64 video front end, included by the package, RTL and testbench
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// ======================================================================
// Color and sync widths
// ======================================================================

// Bits per color channel on the N64 bus
`define PPU_COLOR_W_I 7

// Bits per color channel after expansion
`define PPU_COLOR_W_O 8

// vsync_n, clamp_n, hsync_n, csync_n
`define PPU_SYNC_W 4

// ======================================================================
// Video detection and configuration
// ======================================================================

`define PPU_LINE_CNT_W 10

// Fields longer than this are PAL
`define PPU_PAL_LINE_THRESHOLD 290

`define PPU_GAMMA_W 2

`endif

// File: hdl/ppu_pkg.sv
// Shared types of the N64 post-processing front end, referenced by scoped name from each block
`include "ppu_defines.svh"

package ppu_pkg;

  // Active-low sync bits as they appear in the sync word
  typedef struct packed {
    logic vsync_n;
    logic clamp_n;
    logic hsync_n;
    logic csync_n;
  } sync_bits_t;

  typedef struct packed {
    logic [`PPU_COLOR_W_I-`PPU_SYNC_W-1:0] pad;
    sync_bits_t                             sync;
  } vd_sync_word_t;

  // nVDSYNC low selects the sync view, high the color view
  typedef union packed {
    logic [`PPU_COLOR_W_I-1:0] color;
    vd_sync_word_t             ctrl;
  } vd_word_u;

  typedef struct packed {
    logic [`PPU_COLOR_W_I-1:0] r;
    logic [`PPU_COLOR_W_I-1:0] g;
    logic [`PPU_COLOR_W_I-1:0] b;
  } rgb21_t;

  typedef struct packed {
    logic [`PPU_COLOR_W_O-1:0] r;
    logic [`PPU_COLOR_W_O-1:0] g;
    logic [`PPU_COLOR_W_O-1:0] b;
  } rgb24_t;

  typedef struct packed {
    sync_bits_t sync;
    rgb21_t     rgb;
  } pix21_t;

  typedef struct packed {
    sync_bits_t sync;
    rgb24_t     rgb;
  } pix24_t;

  // Host configuration word
  typedef struct packed {
    logic [`PPU_GAMMA_W-1:0] gamma_sel;
    logic                    color_16bit;
    logic                    deblur;
  } ppu_cfg_t;

  typedef struct packed {
    logic detected;
    logic pal;
    logic interlaced;
  } vinfo_t;

  typedef struct packed {
    logic     vdata_detected;
    logic     pal;
    logic     interlaced;
    logic     deblur_active;
    ppu_cfg_t cfg;
  } ppu_state_t;

  // Gamma curve codes, code 3 falls back to linear
  parameter logic [`PPU_GAMMA_W-1:0] GAMMA_LINEAR = 2'd0;
  parameter logic [`PPU_GAMMA_W-1:0] GAMMA_BRIGHT = 2'd1;
  parameter logic [`PPU_GAMMA_W-1:0] GAMMA_DARK   = 2'd2;

endpackage

// File: hdl/ppu_config_regs.sv
// Host configuration register with state readback; sits beside the video pipeline it steers
`timescale 1ns/1ns

module ppu_config_regs (
  input  logic                N64_CLK_i,
  input  logic                rst_i,
  input  logic                cfg_we_i,
  input  ppu_pkg::ppu_cfg_t   cfg_wdata_i,
  input  ppu_pkg::vinfo_t     vinfo_i,
  output ppu_pkg::ppu_cfg_t   cfg_o,
  output logic                deblur_active_o,
  output ppu_pkg::ppu_state_t ppu_state_o
);

  ppu_pkg::ppu_cfg_t cfg_q;

  // ======================================================================
  // Configuration word
  // ======================================================================

  // Written value is in force from the next cycle on
  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      cfg_q <= cfg_wdata_i;
    end
  end

  assign cfg_o = cfg_q;

  // Deblur only makes sense on 240p/288p, so interlaced video blocks it
  assign deblur_active_o = cfg_q.deblur & ~vinfo_i.interlaced;

  // ======================================================================
  // State readback
  // ======================================================================

  always_comb begin
    ppu_state_o.vdata_detected = vinfo_i.detected;
    ppu_state_o.pal            = vinfo_i.pal;
    ppu_state_o.interlaced     = vinfo_i.interlaced;
    ppu_state_o.deblur_active  = deblur_active_o;
    ppu_state_o.cfg            = cfg_q;
  end

endmodule

// File: hdl/n64_vinfo_detect.sv
// Video information detection; counts lines per field from the demux sync strobes
`timescale 1ns/1ns
`include "ppu_defines.svh"

module n64_vinfo_detect (
  input  logic                N64_CLK_i,
  input  logic                rst_i,
  input  logic                sync_valid_i,
  input  ppu_pkg::sync_bits_t sync_i,
  output ppu_pkg::vinfo_t     vinfo_o
);

  localparam int LW = `PPU_LINE_CNT_W;

  ppu_pkg::sync_bits_t sync_prev_q;
  logic [LW-1:0]       line_cnt_q;
  logic [LW-1:0]       field_cnt_q;
  logic                vsync_seen_q;
  logic                hs_fall;
  logic                vs_fall;

  // Falling edges between two consecutive sync words
  assign hs_fall = sync_valid_i & sync_prev_q.hsync_n & ~sync_i.hsync_n;
  assign vs_fall = sync_valid_i & sync_prev_q.vsync_n & ~sync_i.vsync_n;

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      sync_prev_q  <= '1;
      line_cnt_q   <= '0;
      field_cnt_q  <= '0;
      vsync_seen_q <= 1'b0;
      vinfo_o      <= '0;
    end else begin
      if (sync_valid_i) begin
        sync_prev_q <= sync_i;
      end

      if (vs_fall) begin
        // A line start in the same word already belongs to the new field
        line_cnt_q   <= hs_fall ? LW'(1) : '0;
        field_cnt_q  <= line_cnt_q;
        vsync_seen_q <= 1'b1;

        // First field is partial, so flags wait for the second vsync
        if (vsync_seen_q) begin
          vinfo_o.detected   <= 1'b1;
          vinfo_o.pal        <= line_cnt_q > LW'(`PPU_PAL_LINE_THRESHOLD);
          vinfo_o.interlaced <= line_cnt_q != field_cnt_q;
        end
      end else if (hs_fall) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

endmodule

// File: hdl/n64_vdemux.sv
// Demultiplexer of the 7-bit N64 video bus into RGB pixels with 240p deblur and 16-bit mode
`timescale 1ns/1ns
`include "ppu_defines.svh"

module n64_vdemux (
  input  logic                N64_CLK_i,
  input  logic                rst_i,
  input  logic                nvdsync_i,
  input  ppu_pkg::vd_word_u   vd_i,
  input  logic                color_16bit_i,
  input  logic                deblur_active_i,
  output logic                sync_valid_o,
  output ppu_pkg::sync_bits_t sync_o,
  output logic                pix_valid_o,
  output ppu_pkg::pix21_t     pix_o
);

  localparam int CW = `PPU_COLOR_W_I;

  // Phase within a unit; idle after B until the next sync word
  localparam logic [1:0] PH_R    = 2'd0;
  localparam logic [1:0] PH_G    = 2'd1;
  localparam logic [1:0] PH_B    = 2'd2;
  localparam logic [1:0] PH_IDLE = 2'd3;

  logic [1:0]    phase_q;
  logic          keep_q;
  logic [CW-1:0] r_q;
  logic [CW-1:0] g_q;
  logic          b_sample;

  // Clears the two LSBs to mimic the 5-bit color of 16-bit framebuffers
  function automatic logic [CW-1:0] mask16(input logic [CW-1:0] c, input logic en);
    mask16 = en ? {c[CW-1:2], 2'b00} : c;
  endfunction

  assign b_sample = nvdsync_i & (phase_q == PH_B);

  // ======================================================================
  // Control
  // ======================================================================

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      phase_q      <= PH_IDLE;
      keep_q       <= 1'b0;
      sync_valid_o <= 1'b0;
      pix_valid_o  <= 1'b0;
    end else begin
      sync_valid_o <= ~nvdsync_i;
      pix_valid_o  <= b_sample & (keep_q | ~deblur_active_i);

      if (!nvdsync_i) begin
        phase_q <= PH_R;
        // Line start restarts the keep pattern with a kept unit
        keep_q  <= vd_i.ctrl.sync.hsync_n ? ~keep_q : 1'b1;
      end else if (phase_q != PH_IDLE) begin
        phase_q <= phase_q + 1'b1;
      end
    end
  end

  // ======================================================================
  // Data capture
  // ======================================================================

  // sync_o holds the nibble of the current unit for the whole unit
  always_ff @(posedge N64_CLK_i) begin
    if (!nvdsync_i) begin
      sync_o <= vd_i.ctrl.sync;
    end else begin
      case (phase_q)
        PH_R: r_q <= vd_i.color;
        PH_G: g_q <= vd_i.color;
        PH_B: begin
          pix_o.sync  <= sync_o;
          pix_o.rgb.r <= mask16(r_q, color_16bit_i);
          pix_o.rgb.g <= mask16(g_q, color_16bit_i);
          pix_o.rgb.b <= mask16(vd_i.color, color_16bit_i);
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/gamma_correct.sv
// Two-stage gamma correction; expands 7-bit colors to 8 bits and applies a computed curve
`timescale 1ns/1ns
`include "ppu_defines.svh"

module gamma_correct (
  input  logic                    N64_CLK_i,
  input  logic                    rst_i,
  input  logic [`PPU_GAMMA_W-1:0] gamma_sel_i,
  input  logic                    pix_valid_i,
  input  ppu_pkg::pix21_t         pix_i,
  output logic                    vout_valid_o,
  output ppu_pkg::pix24_t         vout_o
);

  localparam int CW_I = `PPU_COLOR_W_I;
  localparam int CW_O = `PPU_COLOR_W_O;

  logic [CW_I-1:0]     chan_in [3];
  logic [CW_O-1:0]     e_q     [3];
  logic [CW_O-1:0]     corr_q  [3];
  logic                sub_q;
  logic                valid1_q;
  ppu_pkg::sync_bits_t sync1_q;

  // Repeat the MSB so full scale maps to full scale
  function automatic logic [CW_O-1:0] expand(input logic [CW_I-1:0] c);
    expand = {c, c[CW_I-1]};
  endfunction

  function automatic logic [CW_O-1:0] corr_term(input logic [CW_O-1:0]     e,
                                                input logic [`PPU_GAMMA_W-1:0] sel);
    case (sel)
      ppu_pkg::GAMMA_BRIGHT: corr_term = ({CW_O{1'b1}} - e) >> 2;
      ppu_pkg::GAMMA_DARK:   corr_term = e >> 2;
      ppu_pkg::GAMMA_LINEAR: corr_term = '0;
      default:               corr_term = '0;
    endcase
  endfunction

  assign chan_in[0] = pix_i.rgb.r;
  assign chan_in[1] = pix_i.rgb.g;
  assign chan_in[2] = pix_i.rgb.b;

  always_ff @(posedge N64_CLK_i) begin
    if (rst_i) begin
      valid1_q     <= 1'b0;
      vout_valid_o <= 1'b0;
    end else begin
      valid1_q     <= pix_valid_i;
      vout_valid_o <= valid1_q;
    end
  end

  // Stage 1 expands and forms the term, stage 2 adds or subtracts it
  always_ff @(posedge N64_CLK_i) begin
    for (int i = 0; i < 3; i++) begin
      e_q[i]    <= expand(chan_in[i]);
      corr_q[i] <= corr_term(expand(chan_in[i]), gamma_sel_i);
    end
    sub_q   <= gamma_sel_i == ppu_pkg::GAMMA_DARK;
    sync1_q <= pix_i.sync;

    // No wrap in either direction: e + (255-e)/4 <= 255 and e - e/4 >= 0
    vout_o.sync  <= sync1_q;
    vout_o.rgb.r <= sub_q ? e_q[0] - corr_q[0] : e_q[0] + corr_q[0];
    vout_o.rgb.g <= sub_q ? e_q[1] - corr_q[1] : e_q[1] + corr_q[1];
    vout_o.rgb.b <= sub_q ? e_q[2] - corr_q[2] : e_q[2] + corr_q[2];
  end

endmodule

// File: hdl/n64_ppu_top.sv
// Top level of the N64 post-processing front end; joins config, detection, demux and gamma
`timescale 1ns/1ns
`include "ppu_defines.svh"

module n64_ppu_top (
  input  logic                      N64_CLK_i,
  input  logic                      rst_i,
  input  logic                      nvdsync_i,
  input  logic [`PPU_COLOR_W_I-1:0] vd_i,
  input  logic                      cfg_we_i,
  input  ppu_pkg::ppu_cfg_t         cfg_wdata_i,
  output ppu_pkg::ppu_state_t       ppu_state_o,
  output ppu_pkg::pix24_t           vout_o,
  output logic                      vout_valid_o
);

  ppu_pkg::ppu_cfg_t   cfg;
  ppu_pkg::vinfo_t     vinfo;
  ppu_pkg::sync_bits_t sync;
  ppu_pkg::pix21_t     pix21;
  logic                deblur_active;
  logic                sync_valid;
  logic                pix_valid;

  // ======================================================================
  // Configuration and video information
  // ======================================================================

  ppu_config_regs config_regs_i (
    .N64_CLK_i      (N64_CLK_i),
    .rst_i          (rst_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .vinfo_i        (vinfo),
    .cfg_o          (cfg),
    .deblur_active_o(deblur_active),
    .ppu_state_o    (ppu_state_o)
  );

  n64_vinfo_detect vinfo_detect_i (
    .N64_CLK_i   (N64_CLK_i),
    .rst_i       (rst_i),
    .sync_valid_i(sync_valid),
    .sync_i      (sync),
    .vinfo_o     (vinfo)
  );

  // ======================================================================
  // Pixel pipeline
  // ======================================================================

  n64_vdemux vdemux_i (
    .N64_CLK_i      (N64_CLK_i),
    .rst_i          (rst_i),
    .nvdsync_i      (nvdsync_i),
    .vd_i           (vd_i),
    .color_16bit_i  (cfg.color_16bit),
    .deblur_active_i(deblur_active),
    .sync_valid_o   (sync_valid),
    .sync_o         (sync),
    .pix_valid_o    (pix_valid),
    .pix_o          (pix21)
  );

  gamma_correct gamma_i (
    .N64_CLK_i   (N64_CLK_i),
    .rst_i       (rst_i),
    .gamma_sel_i (cfg.gamma_sel),
    .pix_valid_i (pix_valid),
    .pix_i       (pix21),
    .vout_valid_o(vout_valid_o),
    .vout_o      (vout_o)
  );

endmodule

// File: dv/ppu_tb.sv
// Self-checking testbench of the N64 front end; drives bus fields, config writes and checks pixels
`timescale 1ns/1ns
`include "ppu_defines.svh"

module ppu_tb;

  // Lines driven by the tests set the timeout
  localparam int SHORT_LINES    = 4 * 4;
  localparam int FIELD_LINES    = 3 * 262 + 312 + 313 + 312;
  localparam int TOTAL_UNITS    = (SHORT_LINES + FIELD_LINES) * 4;
  // Resets, config writes and pipeline drains
  localparam int IDLE_CYCLES    = 200;
  localparam int TIMEOUT_CYCLES = TOTAL_UNITS * 4 + 100 + IDLE_CYCLES;

  // Line-count model of the video detection
  typedef struct packed {
    ppu_pkg::sync_bits_t        prev;
    logic [`PPU_LINE_CNT_W-1:0] line_cnt;
    logic [`PPU_LINE_CNT_W-1:0] field_cnt;
    logic                       seen;
    ppu_pkg::vinfo_t            vinfo;
  } field_model_t;

  logic                      n64_clk;
  logic                      rst;
  logic                      nvdsync;
  logic [`PPU_COLOR_W_I-1:0] vd;
  logic                      cfg_we;
  ppu_pkg::ppu_cfg_t         cfg_wdata;
  ppu_pkg::ppu_state_t       ppu_state;
  ppu_pkg::pix24_t           vout;
  logic                      vout_valid;

  ppu_pkg::pix24_t   exp_q[$];
  field_model_t      vmodel;
  ppu_pkg::ppu_cfg_t cfg_model;
  int                unit_pos;
  logic [31:0]       rng;
  int                error_cnt = 0;
  int                cycle_cnt = 0;

  n64_ppu_top dut_i (
    .N64_CLK_i   (n64_clk),
    .rst_i       (rst),
    .nvdsync_i   (nvdsync),
    .vd_i        (vd),
    .cfg_we_i    (cfg_we),
    .cfg_wdata_i (cfg_wdata),
    .ppu_state_o (ppu_state),
    .vout_o      (vout),
    .vout_valid_o(vout_valid)
  );

  initial begin
    n64_clk = 1'b0;
    forever #2 n64_clk = ~n64_clk;
  end

  // ======================================================================
  // Reference functions
  // ======================================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] expect_chan(input logic [6:0] c, input ppu_pkg::ppu_cfg_t cfg);
    int v;
    int e;
    v = cfg.color_16bit ? int'(c & 7'h7c) : int'(c);
    // Channel followed by its own MSB
    e = v * 2 + v / 64;
    case (cfg.gamma_sel)
      ppu_pkg::GAMMA_BRIGHT: e = e + (255 - e) / 4;
      ppu_pkg::GAMMA_DARK:   e = e - e / 4;
      default:               e = e;
    endcase
    return 8'(e);
  endfunction

  function automatic ppu_pkg::pix24_t expect_pix(input ppu_pkg::rgb21_t c,
                                                 input ppu_pkg::sync_bits_t s,
                                                 input ppu_pkg::ppu_cfg_t cfg);
    ppu_pkg::pix24_t p;
    p.sync  = s;
    p.rgb.r = expect_chan(c.r, cfg);
    p.rgb.g = expect_chan(c.g, cfg);
    p.rgb.b = expect_chan(c.b, cfg);
    return p;
  endfunction

  function automatic field_model_t step_vinfo(input field_model_t m,
                                              input ppu_pkg::sync_bits_t s);
    field_model_t n;
    logic         line_start;
    logic         field_start;
    n           = m;
    line_start  = m.prev.hsync_n & ~s.hsync_n;
    field_start = m.prev.vsync_n & ~s.vsync_n;
    n.prev      = s;
    if (field_start) begin
      // Count now belongs to the field that just ended
      if (m.seen) begin
        n.vinfo.detected   = 1'b1;
        n.vinfo.pal        = m.line_cnt > `PPU_PAL_LINE_THRESHOLD;
        n.vinfo.interlaced = m.line_cnt != m.field_cnt;
      end
      n.seen      = 1'b1;
      n.field_cnt = m.line_cnt;
      n.line_cnt  = line_start;
    end else if (line_start) begin
      n.line_cnt = m.line_cnt + 1'b1;
    end
    return n;
  endfunction

  function automatic ppu_pkg::ppu_state_t expect_state(input field_model_t m,
                                                       input ppu_pkg::ppu_cfg_t cfg);
    ppu_pkg::ppu_state_t st;
    st.vdata_detected = m.vinfo.detected;
    st.pal            = m.vinfo.pal;
    st.interlaced     = m.vinfo.interlaced;
    st.deblur_active  = cfg.deblur & ~m.vinfo.interlaced;
    st.cfg            = cfg;
    return st;
  endfunction

  function automatic ppu_pkg::ppu_cfg_t cfg_word(input logic [1:0] gamma, input logic c16,
                                                 input logic dbl);
    ppu_pkg::ppu_cfg_t c;
    c.gamma_sel   = gamma;
    c.color_16bit = c16;
    c.deblur      = dbl;
    return c;
  endfunction

  // ======================================================================
  // Checks
  // ======================================================================

  task automatic fail_run();
    error_cnt++;
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_pix(input ppu_pkg::pix24_t exp, input ppu_pkg::pix24_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns vout_o expected %h got %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_state(input ppu_pkg::ppu_state_t exp, input ppu_pkg::ppu_state_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns ppu_state_o expected %h got %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_state_now();
    @(negedge n64_clk);
    check_state(expect_state(vmodel, cfg_model), ppu_state);
  endtask

  // Every output strobe must match the oldest expected pixel
  always @(negedge n64_clk) begin
    if (vout_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: output pixel at %0t ns arrived when none was expected", $time);
        fail_run();
      end else begin
        check_pix(exp_q.pop_front(), vout);
      end
    end
  end

  always @(posedge n64_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // ======================================================================
  // Stimulus
  // ======================================================================

  task automatic apply_reset();
    @(posedge n64_clk);
    rst     <= 1'b1;
    nvdsync <= 1'b1;
    cfg_we  <= 1'b0;
    repeat (2) @(posedge n64_clk);
    rst       <= 1'b0;
    vmodel    = '0;
    vmodel.prev = '1;
    cfg_model = '0;
    unit_pos  = 0;
  endtask

  task automatic write_cfg(input ppu_pkg::ppu_cfg_t c);
    @(posedge n64_clk);
    cfg_we    <= 1'b1;
    cfg_wdata <= c;
    @(posedge n64_clk);
    cfg_we    <= 1'b0;
    cfg_model = c;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge n64_clk);
      nvdsync <= 1'b1;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      idle(1);
    end
    idle(4);
  endtask

  // One sync word then R, G, B
  task automatic drive_unit(input ppu_pkg::sync_bits_t s);
    ppu_pkg::rgb21_t c;
    logic            deblur_on;
    rng       = xorshift32(rng);
    c.r       = rng[6:0];
    c.g       = rng[14:8];
    c.b       = rng[22:16];
    vmodel    = step_vinfo(vmodel, s);
    unit_pos  = s.hsync_n ? unit_pos + 1 : 0;
    deblur_on = cfg_model.deblur & ~vmodel.vinfo.interlaced;
    if (!deblur_on || unit_pos % 2 == 0) begin
      exp_q.push_back(expect_pix(c, s, cfg_model));
    end
    @(posedge n64_clk);
    nvdsync <= 1'b0;
    vd      <= {3'b000, s};
    @(posedge n64_clk);
    nvdsync <= 1'b1;
    vd      <= c.r;
    @(posedge n64_clk);
    vd      <= c.g;
    @(posedge n64_clk);
    vd      <= c.b;
  endtask

  task automatic drive_line(input logic vsync_n);
    ppu_pkg::sync_bits_t s;
    for (int u = 0; u < 4; u++) begin
      s.vsync_n = vsync_n;
      // Distinct low pulses on clamp_n, hsync_n and csync_n within a line
      s.clamp_n = (u != 1);
      s.hsync_n = (u != 0);
      s.csync_n = (u >= 2);
      drive_unit(s);
    end
  endtask

  task automatic drive_field(input int lines);
    for (int l = 0; l < lines; l++) begin
      drive_line(l != 0);
    end
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial begin
    rst       <= 1'b1;
    nvdsync   <= 1'b1;
    vd        <= '0;
    cfg_we    <= 1'b0;
    cfg_wdata <= '0;
    rng       = 32'hefb6a387;
    apply_reset();

    // Quiet after reset
    idle(20);
    @(negedge n64_clk);
    check_state('0, ppu_state);

    write_cfg(cfg_word(ppu_pkg::GAMMA_LINEAR, 1'b0, 1'b0));
    repeat (4) drive_line(1'b1);
    drain();

    write_cfg(cfg_word(ppu_pkg::GAMMA_BRIGHT, 1'b0, 1'b0));
    check_state_now();
    repeat (4) drive_line(1'b1);
    drain();
    write_cfg(cfg_word(ppu_pkg::GAMMA_DARK, 1'b0, 1'b0));
    check_state_now();
    repeat (4) drive_line(1'b1);
    drain();

    // 16-bit color
    write_cfg(cfg_word(ppu_pkg::GAMMA_LINEAR, 1'b1, 1'b0));
    repeat (4) drive_line(1'b1);
    drain();

    // Progressive NTSC with deblur
    apply_reset();
    write_cfg(cfg_word(ppu_pkg::GAMMA_LINEAR, 1'b0, 1'b1));
    repeat (3) drive_field(262);
    drain();
    check_state_now();

    // Interlaced PAL ignores the deblur request once detected
    apply_reset();
    write_cfg(cfg_word(ppu_pkg::GAMMA_LINEAR, 1'b0, 1'b1));
    drive_field(312);
    drive_field(313);
    drive_field(312);
    drain();
    check_state_now();

    if (error_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/ppu_pkg.sv
hdl/ppu_config_regs.sv
hdl/n64_vinfo_detect.sv
hdl/n64_vdemux.sv
hdl/gamma_correct.sv
hdl/n64_ppu_top.sv
dv/ppu_tb.sv

// File: Bender.yml
package:
  name: n64_ppu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ppu_pkg.sv
      - hdl/ppu_config_regs.sv
      - hdl/n64_vinfo_detect.sv
      - hdl/n64_vdemux.sv
      - hdl/gamma_correct.sv
      - hdl/n64_ppu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/ppu_tb.sv
